// ==== csr_unit_params.svh ====
`ifndef CSR_UNIT_PARAMS_SVH
`define CSR_UNIT_PARAMS_SVH

// register numbers
`define CSR_CRMD          14'h0000
`define CSR_PRMD          14'h0001
`define CSR_ECFG          14'h0004
`define CSR_ESTAT         14'h0005
`define CSR_ERA           14'h0006
`define CSR_BADV          14'h0007
`define CSR_EENTRY        14'h000c
`define CSR_SAVE0         14'h0030
`define CSR_SAVE1         14'h0031
`define CSR_SAVE2         14'h0032
`define CSR_SAVE3         14'h0033
`define CSR_TCFG          14'h0041
`define CSR_TVAL          14'h0042
`define CSR_TICLR         14'h0044

// field positions
`define CRMD_PLV_LO       0
`define CRMD_PLV_HI       1
`define CRMD_IE_BIT       2
`define CRMD_DA_BIT       3
`define CRMD_PG_BIT       4
`define CRMD_DATF_LO      5
`define CRMD_DATF_HI      6
`define CRMD_DATM_LO      7
`define CRMD_DATM_HI      8
`define PRMD_PPLV_LO      0
`define PRMD_PPLV_HI      1
`define PRMD_PIE_BIT      2
`define ECFG_LIE_LO       0
`define ECFG_LIE_HI       12
`define ESTAT_IS_LO       0
`define ESTAT_IS_HI       12
`define ESTAT_IS_SW_LO    0
`define ESTAT_IS_SW_HI    1
`define ESTAT_ECODE_LO    16
`define ESTAT_ECODE_HI    21
`define ESTAT_ESUBCODE_LO 22
`define ESTAT_ESUBCODE_HI 30
`define EENTRY_VA_LO      6
`define EENTRY_VA_HI      31
`define TCFG_EN_BIT       0
`define TCFG_PERIODIC_BIT 1
`define TCFG_INITV_LO     2
`define TCFG_INITV_HI     31
`define TICLR_CLR_BIT     0

// interrupt vector layout, shared by ECFG.LIE and ESTAT.IS
`define INT_HW_LO         2
`define INT_HW_HI         9
`define INT_RSV_BIT       10
`define INT_TI_BIT        11
`define INT_IPI_BIT       12

// exception codes
`define ECODE_ADE         6'h08
`define ECODE_ALE         6'h09
`define ESUBCODE_ADEF     9'h000

`define ECFG_LIE_MASK     13'h1bff  // bit 10 reserved
`define TIMER_IDLE        32'hffff_ffff

`endif

// ==== csr_pkg.sv ====
package csr_pkg;

    // register value, address or write mask
    typedef logic [31:0] csr_word_t;

    typedef logic [13:0] csr_num_t;   // csr number from the instruction

    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    typedef logic [1:0]  plv_t;       // privilege level, 0 is kernel

    // 2 software, 8 hardware, reserved, timer, inter-core
    typedef logic [12:0] int_vec_t;

    typedef logic [7:0]  hw_int_t;

endpackage

// ==== csr_exception_regs.sv ====
`timescale 1ns/1ps
`include "csr_unit_params.svh"

module csr_exception_regs import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      csr_we,
    input  csr_num_t  csr_num,
    input  csr_word_t csr_wmask,
    input  csr_word_t csr_wvalue,
    input  logic      wb_ex,
    input  ecode_t    wb_ecode,
    input  esubcode_t wb_esubcode,
    input  csr_word_t wb_pc,
    input  csr_word_t wb_vaddr,
    input  logic      ertn_flush,
    output logic      crmd_ie,
    output csr_word_t ex_entry,
    output csr_word_t ertn_entry,
    output csr_word_t crmd_value,
    output csr_word_t prmd_value,
    output csr_word_t estat_code_value,
    output csr_word_t era_value,
    output csr_word_t badv_value,
    output csr_word_t eentry_value
);
    plv_t       crmd_plv;
    logic       crmd_da;
    logic       crmd_pg;
    logic [1:0] crmd_datf;
    logic [1:0] crmd_datm;
    plv_t       prmd_pplv;
    logic       prmd_pie;
    ecode_t     estat_ecode;
    esubcode_t  estat_esubcode;
    logic [`EENTRY_VA_HI:`EENTRY_VA_LO] eentry_va;
    logic       crmd_wr;
    logic       addr_err;
    csr_word_t  crmd_merged;
    csr_word_t  prmd_merged;
    csr_word_t  era_merged;
    csr_word_t  eentry_merged;

    // events take the register away from a software write in the same cycle
    assign crmd_wr = csr_we && (csr_num == `CSR_CRMD) && !wb_ex && !ertn_flush;

    assign crmd_merged   = (csr_wmask & csr_wvalue) | (~csr_wmask & crmd_value);
    assign prmd_merged   = (csr_wmask & csr_wvalue) | (~csr_wmask & prmd_value);
    assign era_merged    = (csr_wmask & csr_wvalue) | (~csr_wmask & era_value);
    assign eentry_merged = (csr_wmask & csr_wvalue) | (~csr_wmask & eentry_value);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;  // direct address after reset
            crmd_pg   <= 1'b0;
            crmd_datf <= '0;
            crmd_datm <= '0;
        end else if (wb_ex) begin
            crmd_plv <= '0;     // enter kernel, interrupts off
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (crmd_wr) begin
            crmd_plv  <= crmd_merged[`CRMD_PLV_HI:`CRMD_PLV_LO];
            crmd_ie   <= crmd_merged[`CRMD_IE_BIT];
            crmd_da   <= crmd_merged[`CRMD_DA_BIT];
            crmd_pg   <= crmd_merged[`CRMD_PG_BIT];
            crmd_datf <= crmd_merged[`CRMD_DATF_HI:`CRMD_DATF_LO];
            crmd_datm <= crmd_merged[`CRMD_DATM_HI:`CRMD_DATM_LO];
        end
    end

    // prmd, estat code, era
    always_ff @(posedge clk) begin
        if (wb_ex) begin
            prmd_pplv      <= crmd_plv;
            prmd_pie       <= crmd_ie;
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
            era_value      <= wb_pc;
        end else if (csr_we && !ertn_flush) begin
            if (csr_num == `CSR_PRMD) begin
                prmd_pplv <= prmd_merged[`PRMD_PPLV_HI:`PRMD_PPLV_LO];
                prmd_pie  <= prmd_merged[`PRMD_PIE_BIT];
            end
            if (csr_num == `CSR_ERA) begin
                era_value <= era_merged;
            end
        end
    end

    assign addr_err = (wb_ecode == `ECODE_ADE) || (wb_ecode == `ECODE_ALE);

    always_ff @(posedge clk) begin
        if (wb_ex && addr_err) begin
            // fetch side fault reports the pc itself
            if (wb_ecode == `ECODE_ADE && wb_esubcode == `ESUBCODE_ADEF)
                badv_value <= wb_pc;
            else
                badv_value <= wb_vaddr;
        end
    end

    always_ff @(posedge clk) begin
        if (csr_we && csr_num == `CSR_EENTRY)
            eentry_va <= eentry_merged[`EENTRY_VA_HI:`EENTRY_VA_LO];
    end

    always_comb begin
        crmd_value = '0;
        crmd_value[`CRMD_PLV_HI:`CRMD_PLV_LO]   = crmd_plv;
        crmd_value[`CRMD_IE_BIT]                = crmd_ie;
        crmd_value[`CRMD_DA_BIT]                = crmd_da;
        crmd_value[`CRMD_PG_BIT]                = crmd_pg;
        crmd_value[`CRMD_DATF_HI:`CRMD_DATF_LO] = crmd_datf;
        crmd_value[`CRMD_DATM_HI:`CRMD_DATM_LO] = crmd_datm;

        prmd_value = '0;
        prmd_value[`PRMD_PPLV_HI:`PRMD_PPLV_LO] = prmd_pplv;
        prmd_value[`PRMD_PIE_BIT]               = prmd_pie;

        estat_code_value = '0;  // is bits are merged in by the read mux
        estat_code_value[`ESTAT_ECODE_HI:`ESTAT_ECODE_LO]       = estat_ecode;
        estat_code_value[`ESTAT_ESUBCODE_HI:`ESTAT_ESUBCODE_LO] = estat_esubcode;

        eentry_value = '0;
        eentry_value[`EENTRY_VA_HI:`EENTRY_VA_LO] = eentry_va;
    end

    assign ex_entry   = eentry_value;  // single entry, no refill vector
    assign ertn_entry = era_value;

endmodule

// ==== csr_timer.sv ====
`timescale 1ns/1ps
`include "csr_unit_params.svh"

module csr_timer import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      csr_we,
    input  csr_num_t  csr_num,
    input  csr_word_t csr_wmask,
    input  csr_word_t csr_wvalue,
    output logic      timer_zero,
    output csr_word_t tcfg_value,
    output csr_word_t tval_value
);
    logic      tcfg_en;
    logic      tcfg_periodic;
    logic [`TCFG_INITV_HI:`TCFG_INITV_LO] tcfg_initval;
    logic      tcfg_wr;
    csr_word_t tcfg_next;   // tcfg as it will be after this write
    csr_word_t timer_cnt;

    assign tcfg_wr   = csr_we && (csr_num == `CSR_TCFG);
    assign tcfg_next = (csr_wmask & csr_wvalue) | (~csr_wmask & tcfg_value);

    always_ff @(posedge clk) begin
        if (reset)
            tcfg_en <= 1'b0;
        else if (tcfg_wr)
            tcfg_en <= tcfg_next[`TCFG_EN_BIT];
    end

    always_ff @(posedge clk) begin
        if (tcfg_wr) begin
            tcfg_periodic <= tcfg_next[`TCFG_PERIODIC_BIT];
            tcfg_initval  <= tcfg_next[`TCFG_INITV_HI:`TCFG_INITV_LO];
        end
    end

    // initval counts in units of four cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= `TIMER_IDLE;
        end else if (tcfg_wr && tcfg_next[`TCFG_EN_BIT]) begin
            timer_cnt <= {tcfg_next[`TCFG_INITV_HI:`TCFG_INITV_LO], 2'b00};
        end else if (tcfg_en && timer_cnt != `TIMER_IDLE) begin
            if (timer_zero && tcfg_periodic)
                timer_cnt <= {tcfg_initval, 2'b00};
            else
                timer_cnt <= timer_cnt - 32'd1;  // one-shot wraps to idle
        end
    end

    assign timer_zero = (timer_cnt == '0);

    always_comb begin
        tcfg_value = '0;
        tcfg_value[`TCFG_EN_BIT]                   = tcfg_en;
        tcfg_value[`TCFG_PERIODIC_BIT]             = tcfg_periodic;
        tcfg_value[`TCFG_INITV_HI:`TCFG_INITV_LO]  = tcfg_initval;
    end

    assign tval_value = timer_cnt;

endmodule

// ==== csr_interrupt.sv ====
`timescale 1ns/1ps
`include "csr_unit_params.svh"

module csr_interrupt import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      csr_we,
    input  csr_num_t  csr_num,
    input  csr_word_t csr_wmask,
    input  csr_word_t csr_wvalue,
    input  hw_int_t   hw_int_in,
    input  logic      ipi_int_in,
    input  logic      timer_zero,
    input  logic      crmd_ie,
    output logic      has_int,
    output int_vec_t  ecfg_value,
    output int_vec_t  estat_is_value
);
    int_vec_t   lie_next;
    logic [1:0] sw_next;
    logic       ticlr_clr;

    assign lie_next = (csr_wmask[`ECFG_LIE_HI:`ECFG_LIE_LO] & csr_wvalue[`ECFG_LIE_HI:`ECFG_LIE_LO])
                    | (~csr_wmask[`ECFG_LIE_HI:`ECFG_LIE_LO] & ecfg_value);

    // only the two software bits of is are writable
    assign sw_next = (csr_wmask[`ESTAT_IS_SW_HI:`ESTAT_IS_SW_LO]
                      & csr_wvalue[`ESTAT_IS_SW_HI:`ESTAT_IS_SW_LO])
                   | (~csr_wmask[`ESTAT_IS_SW_HI:`ESTAT_IS_SW_LO]
                      & estat_is_value[`ESTAT_IS_SW_HI:`ESTAT_IS_SW_LO]);

    assign ticlr_clr = csr_we && (csr_num == `CSR_TICLR)
                    && csr_wmask[`TICLR_CLR_BIT] && csr_wvalue[`TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (reset)
            ecfg_value <= '0;
        else if (csr_we && csr_num == `CSR_ECFG)
            ecfg_value <= lie_next & `ECFG_LIE_MASK;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_is_value <= '0;
        end else begin
            if (csr_we && csr_num == `CSR_ESTAT)
                estat_is_value[`ESTAT_IS_SW_HI:`ESTAT_IS_SW_LO] <= sw_next;
            estat_is_value[`INT_HW_HI:`INT_HW_LO] <= hw_int_in;  // sampled levels
            estat_is_value[`INT_RSV_BIT]          <= 1'b0;
            if (timer_zero)
                estat_is_value[`INT_TI_BIT] <= 1'b1;  // set beats clear
            else if (ticlr_clr)
                estat_is_value[`INT_TI_BIT] <= 1'b0;
            estat_is_value[`INT_IPI_BIT] <= ipi_int_in;
        end
    end

    assign has_int = (|(estat_is_value & ecfg_value)) & crmd_ie;

endmodule

// ==== csr_scratch.sv ====
`timescale 1ns/1ps
`include "csr_unit_params.svh"

module csr_scratch import csr_pkg::*; (
    input  logic      clk,
    input  logic      csr_we,
    input  csr_num_t  csr_num,
    input  csr_word_t csr_wmask,
    input  csr_word_t csr_wvalue,
    output csr_word_t save0_value,
    output csr_word_t save1_value,
    output csr_word_t save2_value,
    output csr_word_t save3_value
);
    localparam csr_num_t SAVE_NUM [4] = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3};

    csr_word_t save_q [4];

    for (genvar i = 0; i < 4; i++) begin : g_save
        always_ff @(posedge clk) begin
            if (csr_we && csr_num == SAVE_NUM[i])
                save_q[i] <= (csr_wmask & csr_wvalue) | (~csr_wmask & save_q[i]);
        end
    end

    assign save0_value = save_q[0];
    assign save1_value = save_q[1];
    assign save2_value = save_q[2];
    assign save3_value = save_q[3];

endmodule

// ==== csr_read_mux.sv ====
`timescale 1ns/1ps
`include "csr_unit_params.svh"

module csr_read_mux import csr_pkg::*; (
    input  csr_num_t  csr_num,
    input  csr_word_t crmd_value,
    input  csr_word_t prmd_value,
    input  int_vec_t  ecfg_value,
    input  csr_word_t estat_code_value,
    input  int_vec_t  estat_is_value,
    input  csr_word_t era_value,
    input  csr_word_t badv_value,
    input  csr_word_t eentry_value,
    input  csr_word_t tcfg_value,
    input  csr_word_t tval_value,
    input  csr_word_t save0_value,
    input  csr_word_t save1_value,
    input  csr_word_t save2_value,
    input  csr_word_t save3_value,
    output csr_word_t csr_rvalue
);
    csr_word_t estat_value;
    csr_word_t ecfg_word;

    always_comb begin
        estat_value = estat_code_value;
        estat_value[`ESTAT_IS_HI:`ESTAT_IS_LO] = estat_is_value;
        ecfg_word = '0;
        ecfg_word[`ECFG_LIE_HI:`ECFG_LIE_LO] = ecfg_value;
    end

    always_comb begin
        case (csr_num)
            `CSR_CRMD:   csr_rvalue = crmd_value;
            `CSR_PRMD:   csr_rvalue = prmd_value;
            `CSR_ECFG:   csr_rvalue = ecfg_word;
            `CSR_ESTAT:  csr_rvalue = estat_value;
            `CSR_ERA:    csr_rvalue = era_value;
            `CSR_BADV:   csr_rvalue = badv_value;
            `CSR_EENTRY: csr_rvalue = eentry_value;
            `CSR_SAVE0:  csr_rvalue = save0_value;
            `CSR_SAVE1:  csr_rvalue = save1_value;
            `CSR_SAVE2:  csr_rvalue = save2_value;
            `CSR_SAVE3:  csr_rvalue = save3_value;
            `CSR_TCFG:   csr_rvalue = tcfg_value;
            `CSR_TVAL:   csr_rvalue = tval_value;
            `CSR_TICLR:  csr_rvalue = '0;  // clr is write-only
            default:     csr_rvalue = '0;
        endcase
    end

endmodule

// ==== csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      csr_we,
    input  csr_num_t  csr_num,
    input  csr_word_t csr_wmask,
    input  csr_word_t csr_wvalue,
    output csr_word_t csr_rvalue,
    input  logic      wb_ex,
    input  ecode_t    wb_ecode,
    input  esubcode_t wb_esubcode,
    input  csr_word_t wb_pc,
    input  csr_word_t wb_vaddr,
    input  logic      ertn_flush,
    input  hw_int_t   hw_int_in,
    input  logic      ipi_int_in,
    output logic      has_int,
    output csr_word_t ex_entry,
    output csr_word_t ertn_entry
);
    logic      crmd_ie;
    logic      timer_zero;
    csr_word_t crmd_value;
    csr_word_t prmd_value;
    csr_word_t estat_code_value;
    csr_word_t era_value;
    csr_word_t badv_value;
    csr_word_t eentry_value;
    csr_word_t tcfg_value;
    csr_word_t tval_value;
    int_vec_t  ecfg_value;
    int_vec_t  estat_is_value;
    csr_word_t save0_value;
    csr_word_t save1_value;
    csr_word_t save2_value;
    csr_word_t save3_value;

    csr_exception_regs i_exception_regs (
        .clk, .reset, .csr_we, .csr_num, .csr_wmask, .csr_wvalue,
        .wb_ex, .wb_ecode, .wb_esubcode, .wb_pc, .wb_vaddr, .ertn_flush,
        .crmd_ie, .ex_entry, .ertn_entry,
        .crmd_value, .prmd_value, .estat_code_value,
        .era_value, .badv_value, .eentry_value
    );

    csr_timer i_timer (
        .clk, .reset, .csr_we, .csr_num, .csr_wmask, .csr_wvalue,
        .timer_zero, .tcfg_value, .tval_value
    );

    csr_interrupt i_interrupt (
        .clk, .reset, .csr_we, .csr_num, .csr_wmask, .csr_wvalue,
        .hw_int_in, .ipi_int_in, .timer_zero, .crmd_ie,
        .has_int, .ecfg_value, .estat_is_value
    );

    csr_scratch i_scratch (
        .clk, .csr_we, .csr_num, .csr_wmask, .csr_wvalue,
        .save0_value, .save1_value, .save2_value, .save3_value
    );

    // zero-cycle read path
    csr_read_mux i_read_mux (
        .csr_num, .crmd_value, .prmd_value, .ecfg_value,
        .estat_code_value, .estat_is_value, .era_value, .badv_value,
        .eentry_value, .tcfg_value, .tval_value,
        .save0_value, .save1_value, .save2_value, .save3_value,
        .csr_rvalue
    );

endmodule

// ==== csr_unit_props.sv ====
`timescale 1ns/1ps
`include "csr_unit_params.svh"

module csr_unit_props import csr_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      wb_ex,
    input logic      ertn_flush,
    input logic      crmd_ie,
    input csr_word_t crmd_value,
    input csr_word_t prmd_value
);
    // exception entry drops to kernel with interrupts masked
    a_ex_clears_plv_ie: assert property (@(posedge clk) disable iff (reset)
        wb_ex |=> (crmd_value[`CRMD_PLV_HI:`CRMD_PLV_LO] == 2'b00) && !crmd_ie)
        else $error("plv or ie not cleared after exception entry");

    a_ertn_restores_ie: assert property (@(posedge clk) disable iff (reset)
        (ertn_flush && !wb_ex) |=> (crmd_ie == $past(prmd_value[`PRMD_PIE_BIT])))
        else $error("ie not restored from prmd on return");

    // da comes up set out of reset
    a_reset_da: assert property (@(posedge clk)
        reset |=> crmd_value[`CRMD_DA_BIT])
        else $error("crmd da not set after reset");

endmodule

bind csr_exception_regs csr_unit_props i_props (
    .clk, .reset, .wb_ex, .ertn_flush, .crmd_ie, .crmd_value, .prmd_value
);

// ==== csr_unit_tb.sv ====
`timescale 1ns/1ps
`include "csr_unit_params.svh"

module csr_unit_tb import csr_pkg::*; ();
    localparam int OP_WRITE  = 0;
    localparam int OP_CHECK  = 1;  // model value or'ed with extra bits
    localparam int OP_EXPECT = 2;  // literal expected value
    localparam int OP_INT    = 3;
    localparam int OP_EX     = 4;
    localparam int OP_ERTN   = 5;
    localparam int OP_LINES  = 6;  // value[7:0] hw lines, value[8] ipi
    localparam int OP_WAIT   = 7;

    typedef struct {
        int        op;
        csr_num_t  num;
        csr_word_t mask;
        csr_word_t value;
        ecode_t    ecode;
        esubcode_t esub;
        csr_word_t pc;
        csr_word_t vaddr;
        csr_word_t expected;
    } step_t;

    logic      clk;
    logic      reset;
    logic      csr_we;
    csr_num_t  csr_num;
    csr_word_t csr_wmask;
    csr_word_t csr_wvalue;
    csr_word_t csr_rvalue;
    logic      wb_ex;
    ecode_t    wb_ecode;
    esubcode_t wb_esubcode;
    csr_word_t wb_pc;
    csr_word_t wb_vaddr;
    logic      ertn_flush;
    hw_int_t   hw_int_in;
    logic      ipi_int_in;
    logic      has_int;
    csr_word_t ex_entry;
    csr_word_t ertn_entry;

    step_t       steps[$];
    csr_word_t   model [0:127];
    logic [15:0] lfsr = 16'd39136;
    int          cycles = 0;
    int          limit = 0;
    int          error_count = 0;

    csr_unit i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: test did not finish within %0d cycles", limit);
            $display("Errors found");
            $fatal(1, "simulation stopped by cycle limit");
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];  // x^16+x^14+x^13+x^11+1
        return {s[14:0], fb};
    endfunction

    task automatic rand_word(output csr_word_t w);
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    // bits that software can change in each register
    function automatic csr_word_t writable(input csr_num_t num);
        case (num)
            `CSR_CRMD:   return 32'h0000_01ff;
            `CSR_PRMD:   return 32'h0000_0007;
            `CSR_ECFG:   return 32'h0000_1bff;
            `CSR_ESTAT:  return 32'h0000_0003;
            `CSR_EENTRY: return 32'hffff_ffc0;
            `CSR_TICLR:  return 32'h0;
            default:     return 32'hffff_ffff;
        endcase
    endfunction

    task automatic check_word(input string name, input csr_word_t got, input csr_word_t exp);
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1, "check failed");
        end
    endtask

    task automatic add(input int op, input csr_num_t num, input csr_word_t mask,
                       input csr_word_t value, input csr_word_t expected);
        step_t s;
        s = '{op, num, mask, value, '0, '0, '0, '0, expected};
        steps.push_back(s);
    endtask

    task automatic add_ex(input ecode_t ecode, input esubcode_t esub,
                          input csr_word_t pc, input csr_word_t vaddr);
        step_t s;
        s = '{OP_EX, '0, '0, '0, ecode, esub, pc, vaddr, '0};
        steps.push_back(s);
    endtask

    task automatic apply(input step_t s);
        int        idx;
        csr_word_t m;
        idx = int'(s.num);
        case (s.op)
            OP_WRITE: begin
                csr_we = 1'b1;
                csr_num = s.num;
                csr_wmask = s.mask;
                csr_wvalue = s.value;
                @(posedge clk);
                @(negedge clk);
                csr_we = 1'b0;
                m = writable(s.num) & s.mask;
                model[idx] = (m & s.value) | (~m & model[idx]);
            end
            OP_CHECK, OP_EXPECT: begin
                csr_num = s.num;
                #5;  // read is combinational, sample mid low phase
                if (s.op == OP_CHECK)
                    check_word($sformatf("csr_rvalue[%h]", s.num), csr_rvalue,
                               model[idx] | s.expected);
                else
                    check_word($sformatf("csr_rvalue[%h]", s.num), csr_rvalue, s.expected);
                @(negedge clk);
            end
            OP_INT: begin
                #5;
                check_bit("has_int", has_int, s.expected[0]);
                @(negedge clk);
            end
            OP_EX: begin
                wb_ex = 1'b1;
                wb_ecode = s.ecode;
                wb_esubcode = s.esub;
                wb_pc = s.pc;
                wb_vaddr = s.vaddr;
                @(posedge clk);
                @(negedge clk);
                wb_ex = 1'b0;
                model[`CSR_PRMD] = model[`CSR_CRMD] & 32'h7;
                model[`CSR_CRMD] = model[`CSR_CRMD] & ~32'h7;
                model[`CSR_ERA] = s.pc;
                model[`CSR_ESTAT][30:16] = {s.esub, s.ecode};
                if (s.ecode == `ECODE_ADE && s.esub == `ESUBCODE_ADEF)
                    model[`CSR_BADV] = s.pc;
                else if (s.ecode == `ECODE_ADE || s.ecode == `ECODE_ALE)
                    model[`CSR_BADV] = s.vaddr;
                check_word("ex_entry", ex_entry, model[`CSR_EENTRY]);
            end
            OP_ERTN: begin
                ertn_flush = 1'b1;
                @(posedge clk);
                @(negedge clk);
                ertn_flush = 1'b0;
                model[`CSR_CRMD] = (model[`CSR_CRMD] & ~32'h7) | (model[`CSR_PRMD] & 32'h7);
                check_word("ertn_entry", ertn_entry, model[`CSR_ERA]);
            end
            OP_LINES: begin
                hw_int_in = s.value[7:0];
                ipi_int_in = s.value[8];
                @(negedge clk);
            end
            default: repeat (s.value) @(negedge clk);
        endcase
    endtask

    task automatic build_table();
        csr_word_t r0;
        csr_word_t r1;
        // state right after reset
        add(OP_CHECK, `CSR_CRMD, 0, 0, 0);
        add(OP_INT, 0, 0, 0, 0);
        // scratch and entry registers, full write then partial mask
        for (int i = 0; i < 4; i++) begin
            rand_word(r0);
            add(OP_WRITE, csr_num_t'(`CSR_SAVE0 + i), 32'hffff_ffff, r0, 0);
            add(OP_CHECK, csr_num_t'(`CSR_SAVE0 + i), 0, 0, 0);
        end
        rand_word(r1);
        add(OP_WRITE, `CSR_SAVE2, 32'h00ff_ff00, r1, 0);
        add(OP_CHECK, `CSR_SAVE2, 0, 0, 0);
        rand_word(r0);
        add(OP_WRITE, `CSR_EENTRY, 32'hffff_ffff, r0, 0);
        rand_word(r1);
        add(OP_WRITE, `CSR_EENTRY, 32'h0000_ffff, r1, 0);
        add(OP_CHECK, `CSR_EENTRY, 0, 0, 0);
        add(OP_WRITE, `CSR_CRMD, 32'h0000_0007, 32'h0000_0007, 0);  // plv 3, ie on
        add(OP_CHECK, `CSR_CRMD, 0, 0, 0);
        // exceptions
        add_ex(`ECODE_ALE, 9'h000, 32'h1c00_0104, 32'h8000_2003);
        add(OP_CHECK, `CSR_PRMD, 0, 0, 0);
        add(OP_CHECK, `CSR_CRMD, 0, 0, 0);
        add(OP_CHECK, `CSR_ERA, 0, 0, 0);
        add(OP_CHECK, `CSR_ESTAT, 0, 0, 0);
        add(OP_CHECK, `CSR_BADV, 0, 0, 0);
        add_ex(`ECODE_ADE, `ESUBCODE_ADEF, 32'h1c00_0302, 32'h0000_0040);
        add(OP_CHECK, `CSR_BADV, 0, 0, 0);
        add(OP_CHECK, `CSR_ESTAT, 0, 0, 0);
        // return
        add(OP_WRITE, `CSR_PRMD, 32'h0000_0007, 32'h0000_0006, 0);
        add(OP_ERTN, 0, 0, 0, 0);
        add(OP_CHECK, `CSR_CRMD, 0, 0, 0);
        // interrupts
        add(OP_WRITE, `CSR_CRMD, 32'h0000_0004, 32'h0, 0);
        add(OP_WRITE, `CSR_ESTAT, 32'h0000_0003, 32'h0000_0001, 0);
        add(OP_INT, 0, 0, 0, 0);
        add(OP_WRITE, `CSR_ECFG, 32'h0000_1fff, 32'h0000_0001, 0);
        add(OP_INT, 0, 0, 0, 0);
        add(OP_WRITE, `CSR_CRMD, 32'h0000_0004, 32'h0000_0004, 0);
        add(OP_INT, 0, 0, 0, 1);
        add(OP_WRITE, `CSR_ECFG, 32'h0000_0001, 32'h0, 0);
        add(OP_INT, 0, 0, 0, 0);
        add(OP_WRITE, `CSR_ESTAT, 32'h0000_0003, 32'h0, 0);
        add(OP_LINES, 0, 0, 32'h0000_0001, 0);
        add(OP_CHECK, `CSR_ESTAT, 0, 0, 32'h0000_0004);  // hw line 0 is bit 2
        add(OP_INT, 0, 0, 0, 0);
        add(OP_WRITE, `CSR_ECFG, 32'h0000_0004, 32'h0000_0004, 0);
        add(OP_INT, 0, 0, 0, 1);
        add(OP_LINES, 0, 0, 32'h0000_0100, 0);
        add(OP_CHECK, `CSR_ESTAT, 0, 0, 32'h0000_1000);
        add(OP_INT, 0, 0, 0, 0);
        add(OP_LINES, 0, 0, 32'h0, 0);
        add(OP_WRITE, `CSR_ECFG, 32'h0000_0400, 32'h0000_0400, 0);
        add(OP_CHECK, `CSR_ECFG, 0, 0, 0);
        add(OP_WRITE, `CSR_ECFG, 32'h0000_1fff, 32'h0, 0);
        // one-shot timer, initval 3
        add(OP_WRITE, `CSR_TCFG, 32'hffff_ffff, 32'h0000_000d, 0);
        add(OP_CHECK, `CSR_TCFG, 0, 0, 0);
        add(OP_EXPECT, `CSR_TVAL, 0, 0, 4 * 3 - 1);
        add(OP_WAIT, 0, 0, 4, 0);
        add(OP_EXPECT, `CSR_TVAL, 0, 0, 4 * 3 - 6);
        add(OP_WAIT, 0, 0, 5, 0);
        add(OP_EXPECT, `CSR_TVAL, 0, 0, 0);
        add(OP_CHECK, `CSR_ESTAT, 0, 0, 32'h0000_0800);  // pending one cycle after zero
        add(OP_EXPECT, `CSR_TVAL, 0, 0, `TIMER_IDLE);
        add(OP_WRITE, `CSR_TICLR, 32'h0000_0001, 32'h0000_0001, 0);
        add(OP_CHECK, `CSR_ESTAT, 0, 0, 0);
        add(OP_EXPECT, `CSR_TICLR, 0, 0, 0);
        // periodic timer, initval 2
        add(OP_WRITE, `CSR_TCFG, 32'hffff_ffff, 32'h0000_000b, 0);
        add(OP_WAIT, 0, 0, 8, 0);
        add(OP_EXPECT, `CSR_TVAL, 0, 0, 0);
        add(OP_EXPECT, `CSR_TVAL, 0, 0, 4 * 2);
        add(OP_WRITE, `CSR_TCFG, 32'hffff_ffff, 32'h0, 0);
    endtask

    initial begin
        reset = 1'b1;
        csr_we = 1'b0;
        csr_num = '0;
        csr_wmask = '0;
        csr_wvalue = '0;
        wb_ex = 1'b0;
        wb_ecode = '0;
        wb_esubcode = '0;
        wb_pc = '0;
        wb_vaddr = '0;
        ertn_flush = 1'b0;
        hw_int_in = '0;
        ipi_int_in = 1'b0;
        foreach (model[i]) model[i] = '0;
        model[`CSR_CRMD] = 32'h0000_0008;  // da after reset
        build_table();
        limit = 4 * steps.size() + 8 + 8;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (steps[i]) apply(steps[i]);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== csr_unit.f ====
+incdir+.
csr_pkg.sv
csr_exception_regs.sv
csr_timer.sv
csr_interrupt.sv
csr_scratch.sv
csr_read_mux.sv
csr_unit.sv
csr_unit_props.sv
csr_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the csr unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f csr_unit.f --top-module csr_unit_tb -o sim_csr_unit
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_csr_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "^No errors$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
